//--- common/core_cfg_pkg.sv
// Architectural widths and index types, imported by the rename RTL and its testbench
package core_cfg_pkg;

  // Data path width
  parameter int XLEN = 32;

  // Architectural register file
  parameter int NUM_AREGS = 32;
  parameter int AREG_W = $clog2(NUM_AREGS);

  // Reorder-buffer id width, enough for 128 entries
  parameter int ROB_W = 7;
  parameter int ROBID_W = ROB_W;

  // Register index
  typedef logic [AREG_W-1:0] areg_t;

  // Destination field, top bit set means no destination
  typedef logic [AREG_W:0] dest_t;

  // Reorder-buffer id
  typedef logic [ROBID_W-1:0] robid_t;

  // Register value or result
  typedef logic [XLEN-1:0] data_t;

endpackage

//--- common/rename_msg_pkg.sv
// Operand and retirement message structs passed between the alias table and reorder buffer
package rename_msg_pkg;

  import core_cfg_pkg::*;

  // One renamed source
  // Holds a value when ready, else the zero-extended producer id
  typedef struct packed {
    logic  ready;
    data_t tagval;
  } operand_t;

  // One in-order retirement into the committed values
  // Valid only for entries that have a destination
  typedef struct packed {
    logic  valid;
    areg_t rd;
    data_t result;
  } retire_t;

endpackage

//--- common/wb_if.sv
// Writeback broadcast from the execution units, driven through src and received through sink
`timescale 1ns/100ps

interface wb_if import core_cfg_pkg::*; ();

  // Result strobe, one per cycle at most
  logic   valid;
  // Entry finished with a fault, flushes at the head
  logic   error;
  robid_t robid;
  dest_t  rd;
  data_t  result;

  // Execution side
  modport src (output valid, error, robid, rd, result);

  // Alias table and reorder buffer side
  modport sink (input valid, error, robid, rd, result);

endinterface

//--- rat/rat.sv
// Register alias table, renames one instruction per strobe and returns its two source operands
`timescale 1ns/100ps

module rat import core_cfg_pkg::*, rename_msg_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  // Rename strobe and allocated id
  input  logic     rename_valid,
  input  dest_t    rename_rd,
  input  areg_t    rename_rs1,
  input  areg_t    rename_rs2,
  input  robid_t   alloc_id,

  // Result broadcast
  wb_if.sink       wb,

  // From the reorder buffer
  input  retire_t  retire,
  input  logic     flush,

  // Source results, valid the cycle after rename
  output operand_t rs1_op,
  output operand_t rs2_op
);

  // Per register tables
  data_t  comm_val [NUM_AREGS];
  robid_t tag_tbl  [NUM_AREGS];
  data_t  spec_val [NUM_AREGS];
  // Ready means committed or speculative value is present
  logic [NUM_AREGS-1:0] ready_bits;
  // Committed means no producer since reset or flush
  logic [NUM_AREGS-1:0] committed_bits;

  // Writeback seen last cycle
  logic   prev_write;
  robid_t prev_robid;
  areg_t  prev_rd;
  data_t  prev_result;

  logic wb_write;
  logic ld_tag;
  logic ld_spec;

  // Source addresses and registered reads, index 0 is rs1
  areg_t      src_reg [2];
  logic [1:0] spec_hit;
  logic [1:0] rd_ready;
  logic [1:0] rd_committed;
  data_t      rd_comm [2];
  data_t      rd_spec [2];
  robid_t     rd_tag  [2];
  logic [1:0] fwd_prev;
  logic [1:0] fwd_cur;
  operand_t   src_op  [2];

  assign src_reg[0] = rename_rs1;
  assign src_reg[1] = rename_rs2;

  // Faulted or no-destination results never reach the tables
  assign wb_write = wb.valid & ~wb.error & ~wb.rd[AREG_W];
  assign ld_tag   = rename_valid & ~rename_rd[AREG_W];
  // Only the newest producer of a register may update it
  assign ld_spec  = prev_write && (tag_tbl[prev_rd] == prev_robid);

  // Speculative write landing at the same edge as the read
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      spec_hit[i] = ld_spec && (src_reg[i] == prev_rd);
    end
  end

  // Committed values, zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < NUM_AREGS; r++) begin
        comm_val[r] <= '0;
      end
    end else if (retire.valid) begin
      comm_val[retire.rd] <= retire.result;
    end
  end

  // Producer tags and speculative values
  always_ff @(posedge clk) begin
    if (ld_tag) begin
      tag_tbl[rename_rd[AREG_W-1:0]] <= alloc_id;
    end
    if (ld_spec) begin
      spec_val[prev_rd] <= prev_result;
    end
  end

  // State bits, flush wins over rename
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ready_bits     <= '1;
      committed_bits <= '1;
    end else begin
      if (ld_spec) begin
        ready_bits[prev_rd] <= 1'b1;
      end
      // Rename after the spec write so a new producer clears ready
      if (ld_tag) begin
        ready_bits[rename_rd[AREG_W-1:0]]     <= 1'b0;
        committed_bits[rename_rd[AREG_W-1:0]] <= 1'b0;
      end
    end
  end

  // Delayed writeback strobe
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      prev_write <= 1'b0;
    end else begin
      prev_write <= wb_write;
    end
  end

  always_ff @(posedge clk) begin
    prev_robid  <= wb.robid;
    prev_rd     <= wb.rd[AREG_W-1:0];
    prev_result <= wb.result;
  end

  // Source state read on rename, before this instruction's own tag write
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ready     <= '1;
      rd_committed <= '1;
      for (int i = 0; i < 2; i++) begin
        rd_comm[i] <= '0;
      end
    end else if (rename_valid) begin
      for (int i = 0; i < 2; i++) begin
        rd_ready[i]     <= ready_bits[src_reg[i]] | spec_hit[i];
        rd_committed[i] <= committed_bits[src_reg[i]];
        rd_comm[i]      <= comm_val[src_reg[i]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rename_valid) begin
      for (int i = 0; i < 2; i++) begin
        rd_spec[i] <= spec_hit[i] ? prev_result : spec_val[src_reg[i]];
        rd_tag[i]  <= tag_tbl[src_reg[i]];
      end
    end
  end

  // Operand select
  // Tag compares only matter while the source is pending
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      fwd_prev[i] = prev_write && (prev_robid == rd_tag[i]);
      fwd_cur[i]  = wb_write && (wb.robid == rd_tag[i]);
      src_op[i].ready = rd_committed[i] | rd_ready[i] | fwd_prev[i] | fwd_cur[i];
      if (rd_committed[i]) begin
        src_op[i].tagval = rd_comm[i];
      end else if (rd_ready[i]) begin
        src_op[i].tagval = rd_spec[i];
      end else if (fwd_prev[i]) begin
        // Result from the rename cycle, not yet in the table
        src_op[i].tagval = prev_result;
      end else if (fwd_cur[i]) begin
        src_op[i].tagval = wb.result;
      end else begin
        src_op[i].tagval = data_t'(rd_tag[i]);
      end
    end
  end

  assign rs1_op = src_op[0];
  assign rs2_op = src_op[1];

endmodule

//--- rob/rob.sv
// Reorder buffer, hands out ids at rename, marks writebacks done and retires or flushes in order
`timescale 1ns/100ps

module rob import core_cfg_pkg::*, rename_msg_pkg::*; #(
  parameter int ROB_DEPTH = 16
) (
  input  logic    clk,
  input  logic    reset,

  // Rename strobe
  input  logic    rename_valid,
  input  dest_t   rename_rd,

  // Result broadcast
  wb_if.sink      wb,

  // Id for the next rename, always the tail
  output robid_t  alloc_id,
  output logic    rob_full,

  // Registered retirement and flush pulse
  output retire_t retire,
  output logic    flush
);

  localparam int PTR_W = $clog2(ROB_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  ptr_t           head_ptr;
  ptr_t           tail_ptr;
  ptr_t           wb_ptr;
  logic [PTR_W:0] entry_count;

  // Per entry status
  logic [ROB_DEPTH-1:0] done_bits;
  logic [ROB_DEPTH-1:0] error_bits;

  // Per entry payload
  dest_t dest_mem   [ROB_DEPTH];
  data_t result_mem [ROB_DEPTH];

  logic  head_done;
  logic  flush_now;
  logic  retire_valid;
  areg_t retire_rd;
  data_t retire_result;

  // Ids are the low pointer bits
  assign wb_ptr   = wb.robid[PTR_W-1:0];
  assign alloc_id = robid_t'(tail_ptr);
  assign rob_full = (entry_count == ROB_DEPTH);

  // Head is ready to leave
  assign head_done = (entry_count != '0) && done_bits[head_ptr];
  // Faulted head flushes instead of retiring
  assign flush_now = head_done && error_bits[head_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr     <= '0;
      tail_ptr     <= '0;
      entry_count  <= '0;
      done_bits    <= '0;
      error_bits   <= '0;
      flush        <= 1'b0;
      retire_valid <= 1'b0;
    end else if (flush_now) begin
      // Drop every in-flight entry, same-edge rename included
      head_ptr     <= '0;
      tail_ptr     <= '0;
      entry_count  <= '0;
      done_bits    <= '0;
      error_bits   <= '0;
      flush        <= 1'b1;
      retire_valid <= 1'b0;
    end else begin
      flush <= 1'b0;
      // No-destination entries leave quietly
      retire_valid <= head_done && !dest_mem[head_ptr][AREG_W];
      if (rename_valid) begin
        tail_ptr              <= tail_ptr + 1'b1;
        done_bits[tail_ptr]   <= 1'b0;
        error_bits[tail_ptr]  <= 1'b0;
      end
      // Writeback never targets the free tail slot
      if (wb.valid) begin
        done_bits[wb_ptr]  <= 1'b1;
        error_bits[wb_ptr] <= wb.error;
      end
      if (head_done) begin
        head_ptr <= head_ptr + 1'b1;
      end
      case ({rename_valid, head_done})
        2'b10:   entry_count <= entry_count + 1'b1;
        2'b01:   entry_count <= entry_count - 1'b1;
        default: entry_count <= entry_count;
      endcase
    end
  end

  // Entry payload and retirement message body
  always_ff @(posedge clk) begin
    if (rename_valid) begin
      dest_mem[tail_ptr] <= rename_rd;
    end
    if (wb.valid) begin
      result_mem[wb_ptr] <= wb.result;
    end
    if (head_done) begin
      retire_rd     <= dest_mem[head_ptr][AREG_W-1:0];
      retire_result <= result_mem[head_ptr];
    end
  end

  assign retire.valid  = retire_valid;
  assign retire.rd     = retire_rd;
  assign retire.result = retire_result;

endmodule

//--- src/rename_unit.sv
// Rename and retirement core top, alias table plus reorder buffer behind plain ports
`timescale 1ns/100ps

module rename_unit import core_cfg_pkg::*, rename_msg_pkg::*; #(
  parameter int ROB_DEPTH = 16
) (
  input  logic   clk,
  input  logic   reset,

  // Rename request, not while full or flushing
  input  logic   rename_valid,
  input  dest_t  rename_rd,
  input  areg_t  rename_rs1,
  input  areg_t  rename_rs2,

  // Writeback from the execution units
  input  logic   wb_valid,
  input  logic   wb_error,
  input  robid_t wb_robid,
  input  dest_t  wb_rd,
  input  data_t  wb_result,

  output robid_t rename_robid,
  output logic   rob_full,
  output logic   rs1_ready,
  output data_t  rs1_tagval,
  output logic   rs2_ready,
  output data_t  rs2_tagval,
  output logic   rob_flush
);

  wb_if wb_bus ();

  retire_t  retire_msg;
  operand_t rs1_op;
  operand_t rs2_op;

  // Writeback ports onto the shared bundle
  assign wb_bus.valid   = wb_valid;
  assign wb_bus.error   = wb_error;
  assign wb_bus.robid   = wb_robid;
  assign wb_bus.rd      = wb_rd;
  assign wb_bus.result  = wb_result;

  rob #(
    .ROB_DEPTH (ROB_DEPTH)
  ) rob_i (
    .clk          (clk),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .wb           (wb_bus.sink),
    .alloc_id     (rename_robid),
    .rob_full     (rob_full),
    .retire       (retire_msg),
    .flush        (rob_flush)
  );

  rat rat_i (
    .clk          (clk),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_rs1   (rename_rs1),
    .rename_rs2   (rename_rs2),
    .alloc_id     (rename_robid),
    .wb           (wb_bus.sink),
    .retire       (retire_msg),
    .flush        (rob_flush),
    .rs1_op       (rs1_op),
    .rs2_op       (rs2_op)
  );

  // Operand structs out to plain ports
  assign rs1_ready  = rs1_op.ready;
  assign rs1_tagval = rs1_op.tagval;
  assign rs2_ready  = rs2_op.ready;
  assign rs2_tagval = rs2_op.tagval;

endmodule

//--- verification/rename_unit_assertions.sv
// Concurrent checks on reorder-buffer occupancy, flush and retirement, bound into every rob
`timescale 1ns/100ps

module rename_unit_assertions #(
  parameter int ROB_DEPTH = 16
) (
  input logic                       clk,
  input logic                       reset,
  input logic [$clog2(ROB_DEPTH):0] entry_count,
  input logic                       flush,
  input logic                       retire_valid
);

  // Failures so far, collected by the testbench at the end of the run
  int fail_count = 0;

  // Occupancy bound
  count_bound: assert property (@(posedge clk) disable iff (reset)
    entry_count <= ROB_DEPTH)
  else begin
    $error("reorder buffer holds more than %0d entries", ROB_DEPTH);
    fail_count++;
  end

  // Flush is a single-cycle pulse
  flush_pulse: assert property (@(posedge clk) disable iff (reset)
    flush |=> !flush)
  else begin
    $error("flush stayed high for more than one cycle");
    fail_count++;
  end

  // Nothing in flight in the cycle after the flush
  flush_empty: assert property (@(posedge clk) disable iff (reset)
    flush |=> (entry_count == '0))
  else begin
    $error("reorder buffer not empty after flush");
    fail_count++;
  end

  // Faulted head never retires
  flush_no_retire: assert property (@(posedge clk) disable iff (reset)
    !(flush && retire_valid))
  else begin
    $error("retirement and flush in the same cycle");
    fail_count++;
  end

endmodule

bind rob rename_unit_assertions #(
  .ROB_DEPTH (ROB_DEPTH)
) rob_checks_i (
  .clk          (clk),
  .reset        (reset),
  .entry_count  (entry_count),
  .flush        (flush),
  .retire_valid (retire_valid)
);

//--- verification/rename_unit_checker.sv
// Reference model of rename operands, in-order retirement and flush, compared on each falling edge
`timescale 1ns/100ps

module rename_unit_checker import core_cfg_pkg::*; #(
  parameter int ROB_DEPTH = 16
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   rename_valid,
  input  dest_t  rename_rd,
  input  areg_t  rename_rs1,
  input  areg_t  rename_rs2,
  input  logic   wb_valid,
  input  logic   wb_error,
  input  robid_t wb_robid,
  input  data_t  wb_result,
  input  robid_t rename_robid,
  input  logic   rob_full,
  input  logic   rs1_ready,
  input  data_t  rs1_tagval,
  input  logic   rs2_ready,
  input  data_t  rs2_tagval,
  input  logic   rob_flush,
  output logic   model_empty,
  output int     check_count,
  output int     error_count
);

  // Producer status per register
  localparam logic [1:0] ST_PEND = 2'd0;
  localparam logic [1:0] ST_DONE = 2'd1;
  localparam logic [1:0] ST_ERR  = 2'd2;

  // In-flight entry, kept in rename order
  typedef struct packed {
    robid_t id;
    dest_t  rd;
    logic   done;
    logic   error;
    data_t  result;
  } entry_t;

  entry_t entry_q [$];

  // Latest producer and values per register
  logic       has_prod [NUM_AREGS];
  robid_t     prod_id  [NUM_AREGS];
  logic [1:0] prod_st  [NUM_AREGS];
  data_t      prod_val [NUM_AREGS];
  data_t      comm_val [NUM_AREGS];

  robid_t next_id;
  logic   exp_flush;

  // Expected operands of the rename taken at the last edge
  logic   snap_valid;
  logic   snap_ready [2];
  data_t  snap_val   [2];
  robid_t snap_id    [2];

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Reset state, every register committed at zero
  task automatic clear_model();
    entry_q.delete();
    for (int r = 0; r < NUM_AREGS; r++) begin
      has_prod[r] = 1'b0;
      prod_id[r]  = '0;
      prod_st[r]  = ST_PEND;
      prod_val[r] = '0;
      comm_val[r] = '0;
    end
    next_id     = '0;
    exp_flush   = 1'b0;
    snap_valid  = 1'b0;
    model_empty = 1'b1;
  endtask

  // Operand as seen before this rename's own destination update
  task automatic take_snapshot(input int idx, input areg_t src);
    snap_id[idx] = prod_id[src];
    if (!has_prod[src]) begin
      snap_ready[idx] = 1'b1;
      snap_val[idx]   = comm_val[src];
    end else if (prod_st[src] == ST_DONE) begin
      snap_ready[idx] = 1'b1;
      snap_val[idx]   = prod_val[src];
    end else begin
      // Pending or faulted, tag comes back
      snap_ready[idx] = 1'b0;
      snap_val[idx]   = '0;
    end
  endtask

  task automatic check_operand(input int idx, input logic got_ready, input data_t got_val);
    logic  exp_ready;
    data_t exp_val;
    exp_ready = snap_ready[idx];
    exp_val   = snap_ready[idx] ? snap_val[idx] : data_t'(snap_id[idx]);
    // Producer finishing in this cycle is forwarded
    if (!exp_ready && wb_valid && !wb_error && (wb_robid == snap_id[idx])) begin
      exp_ready = 1'b1;
      exp_val   = wb_result;
    end
    check_count++;
    if (got_ready !== exp_ready || got_val !== exp_val) begin
      report_error($sformatf("rs%0d ready %0b value %h, expected ready %0b value %h",
                             idx + 1, got_ready, got_val, exp_ready, exp_val));
    end
  endtask

  task automatic compare_outputs();
    check_count += 3;
    if (rob_flush !== exp_flush) begin
      report_error($sformatf("rob_flush %0b, expected %0b", rob_flush, exp_flush));
    end
    if (rename_robid !== next_id) begin
      report_error($sformatf("rename_robid %0d, expected %0d", rename_robid, next_id));
    end
    if (rob_full !== (entry_q.size() == ROB_DEPTH)) begin
      report_error($sformatf("rob_full %0b with %0d entries", rob_full, entry_q.size()));
    end
    if (snap_valid) begin
      check_operand(0, rs1_ready, rs1_tagval);
      check_operand(1, rs2_ready, rs2_tagval);
    end
  endtask

  task automatic record_writeback();
    entry_t e;
    areg_t  r;
    logic   found;
    found = 1'b0;
    for (int j = 0; j < entry_q.size(); j++) begin
      e = entry_q[j];
      if (e.id == wb_robid && !e.done) begin
        found    = 1'b1;
        e.done   = 1'b1;
        e.error  = wb_error;
        e.result = wb_result;
        entry_q[j] = e;
        r = e.rd[AREG_W-1:0];
        // Only the newest producer changes what a source reads
        if (!e.rd[AREG_W] && has_prod[r] && prod_id[r] == wb_robid) begin
          prod_st[r]  = wb_error ? ST_ERR : ST_DONE;
          prod_val[r] = wb_result;
        end
      end
    end
    if (!found) begin
      error_count++;
      $display("Writeback at %0t ns names id %0d, which is not in flight", $time, wb_robid);
    end
  endtask

  task automatic record_rename();
    entry_t e;
    areg_t  dst;
    take_snapshot(0, rename_rs1);
    take_snapshot(1, rename_rs2);
    snap_valid = 1'b1;
    e.id     = next_id;
    e.rd     = rename_rd;
    e.done   = 1'b0;
    e.error  = 1'b0;
    e.result = '0;
    entry_q.push_back(e);
    if (!rename_rd[AREG_W]) begin
      dst           = rename_rd[AREG_W-1:0];
      has_prod[dst] = 1'b1;
      prod_id[dst]  = next_id;
      prod_st[dst]  = ST_PEND;
    end
    next_id = robid_t'((next_id + 1) % ROB_DEPTH);
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    clear_model();
  end

  // Check this cycle, then step the model over the coming edge
  always @(negedge clk) begin
    entry_t head;
    logic   head_done;
    if (reset) begin
      clear_model();
    end else begin
      compare_outputs();
      head_done  = (entry_q.size() != 0) && entry_q[0].done;
      snap_valid = 1'b0;
      if (head_done && entry_q[0].error) begin
        // Faulted head, rename and writeback at this edge are lost too
        entry_q.delete();
        for (int r = 0; r < NUM_AREGS; r++) begin
          has_prod[r] = 1'b0;
        end
        next_id   = '0;
        exp_flush = 1'b1;
      end else begin
        exp_flush = 1'b0;
        if (head_done) begin
          head = entry_q.pop_front();
          if (!head.rd[AREG_W]) begin
            comm_val[head.rd[AREG_W-1:0]] = head.result;
          end
        end
        if (wb_valid) begin
          record_writeback();
        end
        if (rename_valid) begin
          record_rename();
        end
      end
      model_empty = (entry_q.size() == 0);
    end
  end

endmodule

//--- verification/rename_unit_tb.sv
// Testbench top for the rename unit, runs seeded random renames and writebacks against a model
`timescale 1ns/100ps

module rename_unit_tb import core_cfg_pkg::*; ();

  localparam int ROB_DEPTH      = 16;
  localparam int NUM_RENAMES    = 2000;
  localparam int TIMEOUT_CYCLES = 10 * NUM_RENAMES;
  localparam int CLK_PERIOD     = 20;
  localparam int DRIVE_DELAY    = 2;

  logic   clk;
  logic   reset;
  logic   rename_valid;
  dest_t  rename_rd;
  areg_t  rename_rs1;
  areg_t  rename_rs2;
  logic   wb_valid;
  logic   wb_error;
  robid_t wb_robid;
  dest_t  wb_rd;
  data_t  wb_result;
  robid_t rename_robid;
  logic   rob_full;
  logic   rs1_ready;
  data_t  rs1_tagval;
  logic   rs2_ready;
  data_t  rs2_tagval;
  logic   rob_flush;

  logic model_empty;
  int   check_count;
  int   error_count;
  int   assert_fails;
  int   cycle_count  = 0;
  int   renames_sent = 0;

  // Renamed ids not yet written back, with their destinations
  robid_t open_ids [$];
  dest_t  open_rds [$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  rename_unit #(
    .ROB_DEPTH (ROB_DEPTH)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_rs1   (rename_rs1),
    .rename_rs2   (rename_rs2),
    .wb_valid     (wb_valid),
    .wb_error     (wb_error),
    .wb_robid     (wb_robid),
    .wb_rd        (wb_rd),
    .wb_result    (wb_result),
    .rename_robid (rename_robid),
    .rob_full     (rob_full),
    .rs1_ready    (rs1_ready),
    .rs1_tagval   (rs1_tagval),
    .rs2_ready    (rs2_ready),
    .rs2_tagval   (rs2_tagval),
    .rob_flush    (rob_flush)
  );

  rename_unit_checker #(
    .ROB_DEPTH (ROB_DEPTH)
  ) checker_i (
    .clk          (clk),
    .reset        (reset),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_rs1   (rename_rs1),
    .rename_rs2   (rename_rs2),
    .wb_valid     (wb_valid),
    .wb_error     (wb_error),
    .wb_robid     (wb_robid),
    .wb_result    (wb_result),
    .rename_robid (rename_robid),
    .rob_full     (rob_full),
    .rs1_ready    (rs1_ready),
    .rs1_tagval   (rs1_tagval),
    .rs2_ready    (rs2_ready),
    .rs2_tagval   (rs2_tagval),
    .rob_flush    (rob_flush),
    .model_empty  (model_empty),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycle_count);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // One cycle of stimulus, called just after the rising edge
  task automatic drive_cycle();
    int pick;
    rename_valid = 1'b0;
    wb_valid     = 1'b0;
    wb_error     = 1'b0;
    if (rob_flush) begin
      // Everything in flight is gone
      open_ids.delete();
      open_rds.delete();
    end else begin
      // Writeback picked before this cycle's rename joins the list
      if (open_ids.size() != 0 && $urandom_range(99) < 55) begin
        pick      = $urandom_range(open_ids.size() - 1);
        wb_valid  = 1'b1;
        wb_robid  = open_ids[pick];
        wb_rd     = open_rds[pick];
        wb_result = $urandom();
        wb_error  = ($urandom_range(99) < 3);
        open_ids.delete(pick);
        open_rds.delete(pick);
      end
      if (renames_sent < NUM_RENAMES && !rob_full && $urandom_range(99) < 70) begin
        rename_valid             = 1'b1;
        rename_rd[AREG_W]        = ($urandom_range(99) < 10);
        rename_rd[AREG_W-1:0]    = $urandom();
        rename_rs1               = $urandom();
        rename_rs2               = $urandom();
        open_ids.push_back(rename_robid);
        open_rds.push_back(rename_rd);
        renames_sent++;
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    rename_valid = 1'b0;
    rename_rd    = '0;
    rename_rs1   = '0;
    rename_rs2   = '0;
    wb_valid     = 1'b0;
    wb_error     = 1'b0;
    wb_robid     = '0;
    wb_rd        = '0;
    wb_result    = '0;
    void'($urandom(60));
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    // Traffic until every rename has been written back
    while (renames_sent < NUM_RENAMES || open_ids.size() != 0) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_cycle();
    end
    // Drain through retirement or a last flush
    while (!model_empty) begin
      @(posedge clk);
      #DRIVE_DELAY;
      drive_cycle();
    end
    repeat (2) @(posedge clk);
    assert_fails = dut_i.rob_i.rob_checks_i.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
common/core_cfg_pkg.sv
common/rename_msg_pkg.sv
common/wb_if.sv
rat/rat.sv
rob/rob.sv
src/rename_unit.sv
verification/rename_unit_assertions.sv
verification/rename_unit_checker.sv
verification/rename_unit_tb.sv
